// ==== src/board_pkg.sv ====
/*
 * Shared constants for the board shell: memory geometry, loader framing,
 * LED widths and I/O map, heartbeat period and display width.
 * Other files refer to these by scoped name.
 */
package board_pkg;

	// Memory geometry
	localparam int mem_addr_bits = 10;	// 1024 words
	localparam int word_bits = 32;		// Memory and I/O word

	// Serial loader frame: address word then data word, MSB first
	localparam int loader_frame_bits = 64;

	// LED banks
	localparam int red_led_bits = 18;
	localparam int green_led_bits = 9;	// Top bit is the heartbeat

	// I/O register map
	localparam int io_addr_red = 0;
	localparam int io_addr_green = 1;

	// Cycles between heartbeat toggles
	localparam int heartbeat_ticks = 1000;

	// Segments per display digit
	localparam int seg_bits = 7;

endpackage

// ==== src/axi_read_if.sv ====
/*
 * AXI-style read address and read data channels between the read master
 * and the memory. Transfers happen on edges where valid and ready are high.
 */
`timescale 1ns/1ps

interface axi_read_if;

	logic [board_pkg::word_bits-1:0] araddr;	// Byte-free word address
	logic arvalid;
	logic arready;
	logic [board_pkg::word_bits-1:0] rdata;
	logic rvalid;
	logic rready;

	modport master(output araddr, output arvalid, input arready,
		input rdata, input rvalid, output rready);

	modport slave(input araddr, input arvalid, output arready,
		output rdata, output rvalid, input rready);

endinterface

// ==== src/loader_shift.sv ====
/*
 * Serial program loader. Collects strobed bits MSB first into a frame of
 * one address word and one data word, then pulses a memory write strobe
 * the cycle after the last bit arrives.
 */
`timescale 1ns/1ps

module loader_shift (
	input  logic clk,
	input  logic reset,
	input  logic bit_strobe,
	input  logic bit_in,
	output logic we,
	output logic [board_pkg::mem_addr_bits-1:0] waddr,
	output logic [board_pkg::word_bits-1:0] wdata
);

	logic [board_pkg::loader_frame_bits-1:0] frame;	// Address in upper half
	logic [$clog2(board_pkg::loader_frame_bits)-1:0] bit_count;
	logic last_bit;

	// Strobed bit completes the frame
	assign last_bit = bit_strobe && (bit_count ==
		($clog2(board_pkg::loader_frame_bits))'(board_pkg::loader_frame_bits - 1));

	always_ff @(posedge clk)
	begin
		if (bit_strobe)
			frame <= {frame[board_pkg::loader_frame_bits-2:0], bit_in};	// MSB first
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bit_count <= '0;
			we <= 1'b0;
		end
		else
		begin
			we <= last_bit;	// One-cycle pulse after 64th bit
			if (last_bit)
				bit_count <= '0;	// Restart for next frame
			else if (bit_strobe)
				bit_count <= bit_count + 1'b1;
		end
	end

	// Word index from the address half, upper address bits dropped
	assign waddr = frame[board_pkg::word_bits +: board_pkg::mem_addr_bits];
	assign wdata = frame[board_pkg::word_bits-1:0];

endmodule

// ==== src/axi_mem.sv ====
/*
 * On-chip word memory. Written only through the loader port; read through
 * an AXI-style read slave with one read in flight at a time.
 * Read data appears the cycle after the address is accepted.
 */
`timescale 1ns/1ps

module axi_mem (
	input  logic clk,
	input  logic reset,
	input  logic we,
	input  logic [board_pkg::mem_addr_bits-1:0] waddr,
	input  logic [board_pkg::word_bits-1:0] wdata,
	axi_read_if.slave rd
);

	logic [board_pkg::word_bits-1:0] mem [2**board_pkg::mem_addr_bits];
	logic [board_pkg::mem_addr_bits-1:0] read_index;
	logic addr_accept;

	// Only the low index bits select a word
	assign read_index = rd.araddr[board_pkg::mem_addr_bits-1:0];

	// Idle whenever no read data is waiting
	assign rd.arready = !rd.rvalid;
	assign addr_accept = rd.arvalid && rd.arready;

	// Loader write port
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Read data register
	always_ff @(posedge clk)
	begin
		if (addr_accept)
			rd.rdata <= mem[read_index];
	end

	// Read data valid, held until the master takes it
	always_ff @(posedge clk)
	begin
		if (reset)
			rd.rvalid <= 1'b0;
		else if (addr_accept)
			rd.rvalid <= 1'b1;
		else if (rd.rvalid && rd.rready)
			rd.rvalid <= 1'b0;	// Data taken
	end

endmodule

// ==== src/read_master.sv ====
/*
 * Read master on behalf of the external requester. A read strobe becomes
 * one address transfer and one data transfer; rd_done pulses three cycles
 * after the strobe and rd_data holds the word until the next read.
 */
`timescale 1ns/1ps

module read_master (
	input  logic clk,
	input  logic reset,
	input  logic rd_strobe,
	input  logic [board_pkg::mem_addr_bits-1:0] rd_addr,
	output logic rd_done,
	output logic [board_pkg::word_bits-1:0] rd_data,
	axi_read_if.master ar
);

	logic wait_data;	// Data state; arvalid marks the address state
	logic idle;

	assign idle = !ar.arvalid && !wait_data;
	assign ar.rready = 1'b1;	// Never stalls the slave

	// Request address, zero extended
	always_ff @(posedge clk)
	begin
		if (idle && rd_strobe)
			ar.araddr <= {{(board_pkg::word_bits - board_pkg::mem_addr_bits){1'b0}}, rd_addr};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ar.arvalid <= 1'b0;
			wait_data <= 1'b0;
			rd_done <= 1'b0;
			rd_data <= '0;
		end
		else
		begin
			rd_done <= 1'b0;
			if (idle && rd_strobe)
				ar.arvalid <= 1'b1;	// Strobes in flight are dropped
			else if (ar.arvalid && ar.arready)
			begin
				ar.arvalid <= 1'b0;
				wait_data <= 1'b1;
			end
			else if (wait_data && ar.rvalid)
			begin
				wait_data <= 1'b0;
				rd_data <= ar.rdata;	// Kept for the display
				rd_done <= 1'b1;
			end
		end
	end

endmodule

// ==== src/status_leds.sv ====
/*
 * LED registers written through the I/O port, plus the heartbeat.
 * Address 0 loads the red bank, address 1 the low green bits; the top
 * green bit toggles from a free-running down-counter.
 */
`timescale 1ns/1ps

module status_leds (
	input  logic clk,
	input  logic reset,
	input  logic io_write,
	input  logic [board_pkg::word_bits-1:0] io_addr,
	input  logic [board_pkg::word_bits-1:0] io_data,
	output logic [board_pkg::red_led_bits-1:0] red_led,
	output logic [board_pkg::green_led_bits-1:0] green_led
);

	logic [board_pkg::green_led_bits-2:0] green_reg;	// Software bits
	logic heartbeat;
	logic [$clog2(board_pkg::heartbeat_ticks)-1:0] hb_count;

	// I/O write decode
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			red_led <= '0;
			green_reg <= '0;
		end
		else if (io_write)
		begin
			if (io_addr == board_pkg::io_addr_red)
				red_led <= io_data[board_pkg::red_led_bits-1:0];
			else if (io_addr == board_pkg::io_addr_green)
				green_reg <= io_data[board_pkg::green_led_bits-2:0];
			// Other addresses ignored
		end
	end

	// Heartbeat, toggles once per period
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hb_count <= ($clog2(board_pkg::heartbeat_ticks))'(board_pkg::heartbeat_ticks - 1);
			heartbeat <= 1'b0;
		end
		else if (hb_count == '0)
		begin
			hb_count <= ($clog2(board_pkg::heartbeat_ticks))'(board_pkg::heartbeat_ticks - 1);
			heartbeat <= !heartbeat;
		end
		else
			hb_count <= hb_count - 1'b1;
	end

	assign green_led = {heartbeat, green_reg};

endmodule

// ==== src/hex_display.sv ====
/*
 * Four-digit seven-segment driver. Each nibble of the input maps to
 * segments a..g on bits 0..6, driven active low. hex0 is the low nibble.
 */
`timescale 1ns/1ps

module hex_display (
	input  logic [15:0] value,
	output logic [board_pkg::seg_bits-1:0] hex0,
	output logic [board_pkg::seg_bits-1:0] hex1,
	output logic [board_pkg::seg_bits-1:0] hex2,
	output logic [board_pkg::seg_bits-1:0] hex3
);

	// Active-high segment pattern for one hex digit
	function automatic logic [board_pkg::seg_bits-1:0] seg_decode(input logic [3:0] nibble);
		case (nibble)
			4'h0: seg_decode = 7'h3f;
			4'h1: seg_decode = 7'h06;
			4'h2: seg_decode = 7'h5b;
			4'h3: seg_decode = 7'h4f;
			4'h4: seg_decode = 7'h66;
			4'h5: seg_decode = 7'h6d;
			4'h6: seg_decode = 7'h7d;
			4'h7: seg_decode = 7'h07;
			4'h8: seg_decode = 7'h7f;
			4'h9: seg_decode = 7'h6f;
			4'ha: seg_decode = 7'h77;
			4'hb: seg_decode = 7'h7c;	// Lower case b
			4'hc: seg_decode = 7'h39;
			4'hd: seg_decode = 7'h5e;	// Lower case d
			4'he: seg_decode = 7'h79;
			default: seg_decode = 7'h71;	// F
		endcase
	endfunction

	// Segments are lit by a low level
	assign hex0 = ~seg_decode(value[3:0]);
	assign hex1 = ~seg_decode(value[7:4]);
	assign hex2 = ~seg_decode(value[11:8]);
	assign hex3 = ~seg_decode(value[15:12]);

endmodule

// ==== src/board_top.sv ====
/*
 * Board shell top level. Connects the serial loader, program memory,
 * read master, LED registers and hex display. All ports are plain;
 * the memory read channel runs over one internal interface.
 */
`timescale 1ns/1ps

module board_top (
	input  logic clk,
	input  logic reset,
	input  logic loader_bit_strobe,
	input  logic loader_bit,
	input  logic rd_strobe,
	input  logic [board_pkg::mem_addr_bits-1:0] rd_addr,
	input  logic io_write,
	input  logic [board_pkg::word_bits-1:0] io_addr,
	input  logic [board_pkg::word_bits-1:0] io_data,
	output logic rd_done,
	output logic [board_pkg::word_bits-1:0] rd_data,
	output logic [board_pkg::red_led_bits-1:0] red_led,
	output logic [board_pkg::green_led_bits-1:0] green_led,
	output logic [board_pkg::seg_bits-1:0] hex0,
	output logic [board_pkg::seg_bits-1:0] hex1,
	output logic [board_pkg::seg_bits-1:0] hex2,
	output logic [board_pkg::seg_bits-1:0] hex3
);

	logic mem_we;	// Loader write path
	logic [board_pkg::mem_addr_bits-1:0] mem_waddr;
	logic [board_pkg::word_bits-1:0] mem_wdata;

	axi_read_if rd_bus();	// Read master to memory

	loader_shift loader (
		.clk(clk),
		.reset(reset),
		.bit_strobe(loader_bit_strobe),
		.bit_in(loader_bit),
		.we(mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata)
	);

	axi_mem memory (
		.clk(clk),
		.reset(reset),
		.we(mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.rd(rd_bus.slave)
	);

	read_master reader (
		.clk(clk),
		.reset(reset),
		.rd_strobe(rd_strobe),
		.rd_addr(rd_addr),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.ar(rd_bus.master)
	);

	status_leds leds (
		.clk(clk),
		.reset(reset),
		.io_write(io_write),
		.io_addr(io_addr),
		.io_data(io_data),
		.red_led(red_led),
		.green_led(green_led)
	);

	// Low half of the last fetched word
	hex_display display (
		.value(rd_data[15:0]),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

endmodule

// ==== test/board_tb.sv ====
/*
 * Self-checking testbench for board_top. Loads words through the serial
 * loader, reads them back, drives the I/O port and watches the heartbeat.
 * Concurrent assertions compare the DUT against a local model.
 */
`timescale 1ns/1ps

module board_tb;

	localparam int frames = 16;	// Random loader frames
	localparam int timeout_cycles = 2 * ((frames + 2) * (board_pkg::loader_frame_bits + 8)
		+ 2 * board_pkg::heartbeat_ticks + 100);
	// Active-high segments a..g for digits 0..F
	localparam logic [6:0] seg_on [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
		7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic loader_bit_strobe = 1'b0;
	logic loader_bit = 1'b0;
	logic rd_strobe = 1'b0;
	logic [board_pkg::mem_addr_bits-1:0] rd_addr = '0;
	logic io_write = 1'b0;
	logic [31:0] io_addr = '0;
	logic [31:0] io_data = '0;
	logic rd_done;
	logic [31:0] rd_data;
	logic [board_pkg::red_led_bits-1:0] red_led;
	logic [board_pkg::green_led_bits-1:0] green_led;
	logic [6:0] hex0, hex1, hex2, hex3;

	logic [31:0] model_mem [1024];	// Last word loaded per index
	logic [board_pkg::mem_addr_bits-1:0] written [$];
	logic [31:0] exp_word = '0;
	logic [31:0] shown_word = '0;	// Word the display should show
	logic [17:0] exp_red = '0;
	logic [7:0] exp_green = '0;
	logic [31:0] lfsr_state = 32'h5b7b;
	logic [31:0] addr, data;
	int run_cycles = 0;	// Cycles since reset release
	int cycle_count = 0;
	int error_count = 0;
	int errors_at_start = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	string test_name = "reset";

	board_top DUT (.*);

	initial
	begin
		forever #10 clk = !clk;
	end

	// Galois LFSR with taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsr_state[0]};	// One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [27:0] expected_hex(input logic [15:0] value);
		logic [27:0] segs;
		for (int d = 0; d < 4; d++)
			segs[d*7 +: 7] = ~seg_on[value[d*4 +: 4]];	// Active low
		return segs;
	endfunction

	always @(posedge clk)
	begin
		run_cycles <= reset ? 0 : run_cycles + 1;
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Run stopped, cycle limit %0d reached in test %s", timeout_cycles, test_name);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (reset) rd_done == $past(rd_strobe, 3))
	else
	begin
		error_count = error_count + 1;
		$display("%s: rd_done not exactly 3 cycles after rd_strobe", test_name);
	end

	assert property (@(posedge clk) disable iff (reset) rd_done |-> rd_data == exp_word)
	else
	begin
		error_count = error_count + 1;
		$display("mismatch %s read data expected %h actual %h", test_name, exp_word, rd_data);
	end

	assert property (@(posedge clk) disable iff (reset)
		{hex3, hex2, hex1, hex0} == expected_hex(shown_word[15:0]))
	else
	begin
		error_count = error_count + 1;
		$display("mismatch %s hex digits expected %h actual %h", test_name,
			expected_hex(shown_word[15:0]), {hex3, hex2, hex1, hex0});
	end

	assert property (@(posedge clk) disable iff (reset)
		$past(io_write) |-> red_led == exp_red && green_led[7:0] == exp_green)
	else
	begin
		error_count = error_count + 1;
		$display("mismatch %s LEDs expected %h actual %h", test_name,
			{exp_red, exp_green}, {red_led, green_led[7:0]});
	end

	// Heartbeat toggles every heartbeat_ticks cycles from reset release
	assert property (@(posedge clk) disable iff (reset)
		green_led[8] == 1'((run_cycles / board_pkg::heartbeat_ticks) % 2))
	else
	begin
		error_count = error_count + 1;
		$display("mismatch %s heartbeat expected %0d actual %b", test_name,
			(run_cycles / board_pkg::heartbeat_ticks) % 2, green_led[8]);
	end

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		if (error_count == errors_at_start)
			tests_passed++;
		else
			tests_failed++;
		$display("%s: %s", test_name, (error_count == errors_at_start) ? "pass" : "fail");
	endtask

	task automatic send_frame(input logic [31:0] frame_addr, input logic [31:0] frame_data);
		logic [63:0] frame;
		frame = {frame_addr, frame_data};
		for (int i = 63; i >= 0; i--)
		begin
			loader_bit_strobe = 1'b1;	// MSB first
			loader_bit = frame[i];
			@(posedge clk);
			#2;
		end
		loader_bit_strobe = 1'b0;
		model_mem[frame_addr[9:0]] = frame_data;	// Upper address bits dropped
		written.push_back(frame_addr[9:0]);
		repeat (2) @(posedge clk);	// Write strobe then memory update
		#2;
	endtask

	task automatic read_word(input logic [board_pkg::mem_addr_bits-1:0] index);
		bit seen;
		seen = 1'b0;
		rd_addr = index;
		rd_strobe = 1'b1;
		exp_word = model_mem[index];
		@(posedge clk);
		#2;
		rd_strobe = 1'b0;
		for (int n = 0; n < 6 && !seen; n++)
		begin
			if (n > 0)
			begin
				@(posedge clk);
				#2;
			end
			seen = rd_done;
		end
		if (!seen)
		begin
			error_count = error_count + 1;
			$display("%s: no rd_done after read of index %0d", test_name, index);
		end
		else
			shown_word = exp_word;	// Display follows the fetched word
		@(posedge clk);	// Let the done cycle be checked
		#2;
	endtask

	task automatic write_io(input logic [31:0] wr_addr, input logic [31:0] wr_data);
		io_write = 1'b1;
		io_addr = wr_addr;
		io_data = wr_data;
		@(posedge clk);
		#2;
		io_write = 1'b0;
		if (wr_addr == 32'd0)
			exp_red = wr_data[17:0];
		else if (wr_addr == 32'd1)
			exp_green = wr_data[7:0];
	endtask

	initial
	begin
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		start_test("reset values");
		assert (red_led == '0 && green_led == '0 && rd_data == '0)
		else
		begin
			error_count = error_count + 1;
			$display("mismatch %s expected %h actual %h", test_name, 59'd0,
				{red_led, green_led, rd_data});
		end
		repeat (5) @(posedge clk);	// No requests while idle
		#2;
		end_test();

		start_test("loader round-trip");
		for (int i = 0; i < frames; i++)
		begin
			take_bits(32, addr);
			if (i >= 8)
				addr[9:0] = written[i-8];	// Reuse an index with new upper bits
			take_bits(32, data);
			send_frame(addr, data);
		end
		foreach (written[k])
			read_word(written[k]);
		end_test();

		start_test("read timing and display");
		send_frame(32'hffff_f3ff, 32'h1234_f00f);
		send_frame(32'h0000_0155, 32'hffff_0000);
		read_word(10'h3ff);
		read_word(10'h155);
		read_word(written[0]);
		end_test();

		start_test("io decode");
		take_bits(32, data);
		write_io(32'd0, data);
		take_bits(32, data);
		write_io(32'd1, data);
		write_io(32'd2, 32'hffff_ffff);	// Unmapped addresses
		write_io(32'h100, 32'h0);
		write_io(32'hffff_ffff, 32'h0);
		repeat (2) @(posedge clk);
		#2;
		end_test();

		start_test("heartbeat");
		while (run_cycles < 2 * board_pkg::heartbeat_ticks + 4)
		begin
			@(posedge clk);
			#2;
		end
		end_test();

		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== src.f ====
src/board_pkg.sv
src/axi_read_if.sv
src/loader_shift.sv
src/axi_mem.sv
src/read_master.sv
src/status_leds.sv
src/hex_display.sv
src/board_top.sv
test/board_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the board testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module board_tb -o board_sim &&
./obj_dir/board_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
